// ==== filelist.f ====
verilog/issueIsaPkg.sv
verilog/issueBundlePkg.sv
verilog/opcodeClassifier.sv
verilog/bundleAcceptor.sv
verilog/issueQueue.sv
verilog/issueTop.sv
sim/issueTb_sva.sv
sim/issueTb.sv

// ==== Makefile ====
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
		--top-module issueTb \
		--Mdir $(OBJ_DIR) -o issueSim \
		-f filelist.f

run: compile
	./$(OBJ_DIR)/issueSim

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/issueTb.sv ====
module issueTb;
    import issueIsaPkg::*;
    import issueBundlePkg::*;

    localparam int SLOTS          = 8;
    localparam int DEPTH          = 16;
    localparam int NUM_ROWS       = 8;
    localparam int OBSERVE_CYCLES = 20;
    localparam int DRAIN_CYCLES   = 300;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_AMO    = 7'b0101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    typedef struct packed {
        logic [SLOTS-1:0][31:0] words;
        logic                   hasBranch;
        logic [3:0]             branchIndex;
        logic [4:0]             aluCount;
        logic [4:0]             lsuCount;
        logic [4:0]             csrCount;
        logic                   stallAlu;
    } stimRow_t;

    logic              w_fire00_1;
    logic              rstn;
    logic              bundleReq;
    logic              bundleAck;
    inst_t [SLOTS-1:0] bundleIn;
    bundleCtl_t        ctlIn;
    logic [2:0]        reqVec;
    logic [2:0]        ackVec;
    inst_t             instVec [3];

    stimRow_t    stimTable [NUM_ROWS];
    // index 0 ALU, 1 LSU, 2 CSR
    logic [31:0] expQ [3][$];
    int          seed = 15564;
    bit          aluStall;
    int          stalledAluOps;

    issueTop #(
        .BUNDLE_SLOTS(SLOTS),
        .QUEUE_DEPTH (DEPTH)
    ) issueTop_i (
        .w_fire00_1 (w_fire00_1),
        .rstn       (rstn),
        .i_bundleReq(bundleReq),
        .o_bundleAck(bundleAck),
        .i_bundle   (bundleIn),
        .i_bundleCtl(ctlIn),
        .o_aluReq   (reqVec[0]),
        .i_aluAck   (ackVec[0]),
        .o_aluInst  (instVec[0]),
        .o_lsuReq   (reqVec[1]),
        .i_lsuAck   (ackVec[1]),
        .o_lsuInst  (instVec[1]),
        .o_csrReq   (reqVec[2]),
        .i_csrAck   (ackVec[2]),
        .o_csrInst  (instVec[2])
    );

    initial begin
        w_fire00_1 = 1'b0;
        forever #2 w_fire00_1 = ~w_fire00_1;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("[FAIL] time %0t: %s expected %h, actual %h",
                               $time, name, expVal, actVal));
        end
    endtask

    function automatic string unitName(input int u);
        case (u)
            0: return "o_aluInst";
            1: return "o_lsuInst";
            default: return "o_csrInst";
        endcase
    endfunction

    function automatic int pendingCount();
        return expQ[0].size() + expQ[1].size() + expQ[2].size();
    endfunction

    // body bits tag each word with its row and slot
    task automatic defineRow(
        input int                    r,
        input logic [0:SLOTS-1][6:0] ops,
        input logic                  hasBr,
        input int                    brIdx,
        input int                    alu,
        input int                    lsu,
        input int                    csr,
        input logic                  stall
    );
        for (int s = 0; s < SLOTS; s++) begin
            stimTable[r].words[s] = {9'(r * 37 + s), 8'(r), 8'(s), ops[s]};
        end
        stimTable[r].hasBranch   = hasBr;
        stimTable[r].branchIndex = 4'(brIdx);
        stimTable[r].aluCount    = 5'(alu);
        stimTable[r].lsuCount    = 5'(lsu);
        stimTable[r].csrCount    = 5'(csr);
        stimTable[r].stallAlu    = stall;
    endtask

    task automatic buildTable();
        defineRow(0, {OP_LOAD, OP_OP, OP_STORE, OP_SYSTEM, OP_AMO, OP_OPIMM, OP_LOAD, OP_SYSTEM},
                  1'b0, 0, 2, 4, 2, 1'b0);
        // branch in slot 2 cuts the rest
        defineRow(1, {OP_OP, OP_LOAD, OP_BRANCH, OP_SYSTEM, OP_STORE, OP_OP, OP_OPIMM, OP_LOAD},
                  1'b1, 2, 2, 1, 0, 1'b0);
        defineRow(2, {OP_SYSTEM, OP_STORE, OP_LUI, OP_AMO, OP_OPIMM, OP_LOAD, OP_SYSTEM, OP_OP},
                  1'b0, 0, 3, 3, 2, 1'b0);
        defineRow(3, {OP_STORE, OP_OPIMM, OP_OPIMM, OP_SYSTEM, OP_LOAD, OP_BRANCH, OP_OP, OP_AMO},
                  1'b1, 5, 3, 2, 1, 1'b0);
        // three full ALU bundles against a stalled unit
        defineRow(4, {OP_OPIMM, OP_OP, OP_LUI, OP_OPIMM, OP_OP, OP_OPIMM, OP_LUI, OP_OP},
                  1'b0, 0, 8, 0, 0, 1'b1);
        defineRow(5, {OP_OP, OP_OPIMM, OP_OPIMM, OP_LUI, OP_OP, OP_OP, OP_OPIMM, OP_LUI},
                  1'b0, 0, 8, 0, 0, 1'b1);
        defineRow(6, {OP_LUI, OP_OP, OP_OPIMM, OP_OP, OP_LUI, OP_OPIMM, OP_OP, OP_OPIMM},
                  1'b1, 7, 8, 0, 0, 1'b1);
        defineRow(7, {OP_AMO, OP_SYSTEM, OP_OP, OP_LOAD, OP_LUI, OP_STORE, OP_SYSTEM, OP_OPIMM},
                  1'b0, 0, 3, 3, 2, 1'b0);
    endtask

    // expected per-unit order from the opcode rule
    task automatic modelBundle(input int r);
        int         counts [3];
        int         cls;
        logic [6:0] opc;

        counts = '{0, 0, 0};
        for (int s = 0; s < SLOTS; s++) begin
            if (!stimTable[r].hasBranch || s <= int'(stimTable[r].branchIndex)) begin
                opc = stimTable[r].words[s][6:0];
                case (opc)
                    OP_LOAD, OP_STORE, OP_AMO: cls = 1;
                    OP_SYSTEM: cls = 2;
                    default: cls = 0;
                endcase
                expQ[cls].push_back(stimTable[r].words[s]);
                counts[cls]++;
            end
        end
        checkValue($sformatf("row %0d ALU count", r), 32'(stimTable[r].aluCount), 32'(counts[0]));
        checkValue($sformatf("row %0d LSU count", r), 32'(stimTable[r].lsuCount), 32'(counts[1]));
        checkValue($sformatf("row %0d CSR count", r), 32'(stimTable[r].csrCount), 32'(counts[2]));
    endtask

    task automatic sendBundle(input int r, input bit expectBlock);
        @(negedge w_fire00_1);
        bundleIn          = stimTable[r].words;
        ctlIn.hasBranch   = stimTable[r].hasBranch;
        ctlIn.branchIndex = stimTable[r].branchIndex;
        bundleReq         = 1'b1;
        modelBundle(r);
        if (expectBlock) begin
            repeat (OBSERVE_CYCLES) begin
                @(negedge w_fire00_1);
                if (bundleAck) begin
                    abortRun($sformatf("row %0d was accepted while the ALU queue was full", r));
                end
            end
            aluStall      = 1'b0;
            stalledAluOps = 0;
        end
        @(negedge w_fire00_1);
        while (!bundleAck) begin
            @(negedge w_fire00_1);
        end
        bundleReq = 1'b0;
        // garbage after ack, a late capture would show up
        bundleIn  = ~stimTable[r].words;
        @(negedge w_fire00_1);
        while (bundleAck) begin
            @(negedge w_fire00_1);
        end
    endtask

    task automatic serveUnit(input int u);
        int          waitCycles;
        logic [31:0] expInst;

        forever begin
            @(negedge w_fire00_1);
            if (reqVec[u] && !(u == 0 && aluStall)) begin
                waitCycles = $random(seed) & 3;
                repeat (waitCycles) @(negedge w_fire00_1);
                if (expQ[u].size() == 0) begin
                    abortRun($sformatf("%s delivered an instruction that was not expected",
                                       unitName(u)));
                end
                expInst = expQ[u].pop_front();
                checkValue(unitName(u), expInst, instVec[u]);
                ackVec[u] = 1'b1;
                @(negedge w_fire00_1);
                while (reqVec[u]) begin
                    @(negedge w_fire00_1);
                end
                ackVec[u] = 1'b0;
            end
        end
    endtask

    initial begin
        bit blocked;

        rstn          = 1'b0;
        bundleReq     = 1'b0;
        bundleIn      = '0;
        ctlIn         = '0;
        ackVec        = '0;
        aluStall      = 1'b0;
        stalledAluOps = 0;
        buildTable();
        fork
            serveUnit(0);
            serveUnit(1);
            serveUnit(2);
        join_none

        repeat (8) @(negedge w_fire00_1);
        rstn = 1'b1;
        @(negedge w_fire00_1);
        checkValue("o_bundleAck", 32'd0, 32'(bundleAck));
        repeat (6) begin
            checkValue("o_aluReq", 32'd0, 32'(reqVec[0]));
            checkValue("o_lsuReq", 32'd0, 32'(reqVec[1]));
            checkValue("o_csrReq", 32'd0, 32'(reqVec[2]));
            @(negedge w_fire00_1);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            blocked = 1'b0;
            if (stimTable[r].stallAlu) begin
                if (!aluStall) begin
                    // ALU link must be idle and empty before stalling
                    while (expQ[0].size() != 0 || reqVec[0] || ackVec[0]) begin
                        @(negedge w_fire00_1);
                    end
                    aluStall      = 1'b1;
                    stalledAluOps = 0;
                end
                blocked = (stalledAluOps + int'(stimTable[r].aluCount)) > DEPTH;
                if (!blocked) begin
                    stalledAluOps += int'(stimTable[r].aluCount);
                end
            end else begin
                aluStall = 1'b0;
            end
            sendBundle(r, blocked);
        end

        for (int i = 0; i < DRAIN_CYCLES && pendingCount() != 0; i++) begin
            @(negedge w_fire00_1);
        end
        repeat (10) @(negedge w_fire00_1);
        if (pendingCount() != 0) begin
            abortRun($sformatf("%0d instructions were never delivered", pendingCount()));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // budget of ten cycles per slot plus slack
    initial begin
        repeat (NUM_ROWS * SLOTS * 10 + 200) @(posedge w_fire00_1);
        abortRun("run timed out waiting for the DUT");
    end

endmodule

// ==== sim/issueTb_sva.sv ====
module handshakeChecks (
    input logic w_fire00_1,
    input logic rstn,
    input logic i_bundleReq,
    input logic i_bundleAck,
    input logic i_push,
    input logic i_aluReq,
    input logic i_aluAck,
    input logic i_lsuReq,
    input logic i_lsuAck,
    input logic i_csrReq,
    input logic i_csrAck
);

    // ack answers a request seen at the previous edge
    ackNeedsReq: assert property (@(posedge w_fire00_1) disable iff (!rstn)
        $rose(i_bundleAck) |-> $past(i_bundleReq))
        else $error("bundle ack rose without a request");

    // each queue holds req until the unit acks
    aluReqHeld: assert property (@(posedge w_fire00_1) disable iff (!rstn)
        $fell(i_aluReq) |-> $past(i_aluAck))
        else $error("ALU req dropped before ack");

    lsuReqHeld: assert property (@(posedge w_fire00_1) disable iff (!rstn)
        $fell(i_lsuReq) |-> $past(i_lsuAck))
        else $error("LSU req dropped before ack");

    csrReqHeld: assert property (@(posedge w_fire00_1) disable iff (!rstn)
        $fell(i_csrReq) |-> $past(i_csrAck))
        else $error("CSR req dropped before ack");

    // push opens exactly one bundle handshake
    pushOnce: assert property (@(posedge w_fire00_1) disable iff (!rstn)
        i_push |-> !i_bundleAck ##1 i_bundleAck)
        else $error("push outside a fresh bundle handshake");

endmodule

bind issueTop handshakeChecks linkChecks (
    .w_fire00_1 (w_fire00_1),
    .rstn       (rstn),
    .i_bundleReq(i_bundleReq),
    .i_bundleAck(o_bundleAck),
    .i_push     (push),
    .i_aluReq   (o_aluReq),
    .i_aluAck   (i_aluAck),
    .i_lsuReq   (o_lsuReq),
    .i_lsuAck   (i_lsuAck),
    .i_csrReq   (o_csrReq),
    .i_csrAck   (i_csrAck)
);

// ==== verilog/issueTop.sv ====
module issueTop #(
    parameter int BUNDLE_SLOTS = 8,
    parameter int QUEUE_DEPTH  = 16
) (
    input  logic                                  w_fire00_1,
    input  logic                                  rstn,
    input  logic                                  i_bundleReq,
    output logic                                  o_bundleAck,
    input  issueIsaPkg::inst_t [BUNDLE_SLOTS-1:0] i_bundle,
    input  issueBundlePkg::bundleCtl_t            i_bundleCtl,
    output logic                                  o_aluReq,
    input  logic                                  i_aluAck,
    output issueIsaPkg::inst_t                    o_aluInst,
    output logic                                  o_lsuReq,
    input  logic                                  i_lsuAck,
    output issueIsaPkg::inst_t                    o_lsuInst,
    output logic                                  o_csrReq,
    input  logic                                  i_csrAck,
    output issueIsaPkg::inst_t                    o_csrInst
);
    import issueIsaPkg::*;
    import issueBundlePkg::*;

    classCount_t              counts;
    inst_t [BUNDLE_SLOTS-1:0] aluList;
    inst_t [BUNDLE_SLOTS-1:0] lsuList;
    inst_t [BUNDLE_SLOTS-1:0] csrList;
    logic [COUNT_W-1:0]       aluFree;
    logic [COUNT_W-1:0]       lsuFree;
    logic [COUNT_W-1:0]       csrFree;
    logic                     push;

    opcodeClassifier #(
        .BUNDLE_SLOTS(BUNDLE_SLOTS)
    ) classifier (
        .i_bundle   (i_bundle),
        .i_bundleCtl(i_bundleCtl),
        .o_counts   (counts),
        .o_aluList  (aluList),
        .o_lsuList  (lsuList),
        .o_csrList  (csrList)
    );

    bundleAcceptor acceptor (
        .w_fire00_1 (w_fire00_1),
        .rstn       (rstn),
        .i_bundleReq(i_bundleReq),
        .o_bundleAck(o_bundleAck),
        .i_counts   (counts),
        .i_aluFree  (aluFree),
        .i_lsuFree  (lsuFree),
        .i_csrFree  (csrFree),
        .o_push     (push)
    );

    // one push strobe, each queue takes its own share
    issueQueue #(
        .BUNDLE_SLOTS(BUNDLE_SLOTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) aluQueue (
        .w_fire00_1(w_fire00_1),
        .rstn      (rstn),
        .i_push    (push),
        .i_list    (aluList),
        .i_count   (counts.aluCount),
        .o_free    (aluFree),
        .o_req     (o_aluReq),
        .i_ack     (i_aluAck),
        .o_inst    (o_aluInst)
    );

    issueQueue #(
        .BUNDLE_SLOTS(BUNDLE_SLOTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) lsuQueue (
        .w_fire00_1(w_fire00_1),
        .rstn      (rstn),
        .i_push    (push),
        .i_list    (lsuList),
        .i_count   (counts.lsuCount),
        .o_free    (lsuFree),
        .o_req     (o_lsuReq),
        .i_ack     (i_lsuAck),
        .o_inst    (o_lsuInst)
    );

    issueQueue #(
        .BUNDLE_SLOTS(BUNDLE_SLOTS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) csrQueue (
        .w_fire00_1(w_fire00_1),
        .rstn      (rstn),
        .i_push    (push),
        .i_list    (csrList),
        .i_count   (counts.csrCount),
        .o_free    (csrFree),
        .o_req     (o_csrReq),
        .i_ack     (i_csrAck),
        .o_inst    (o_csrInst)
    );

endmodule

// ==== verilog/issueQueue.sv ====
module issueQueue #(
    parameter int BUNDLE_SLOTS = 8,
    parameter int QUEUE_DEPTH  = 16
) (
    input  logic                                  w_fire00_1,
    input  logic                                  rstn,
    input  logic                                  i_push,
    input  issueIsaPkg::inst_t [BUNDLE_SLOTS-1:0] i_list,
    input  logic [issueBundlePkg::COUNT_W-1:0]    i_count,
    output logic [issueBundlePkg::COUNT_W-1:0]    o_free,
    output logic                                  o_req,
    input  logic                                  i_ack,
    output issueIsaPkg::inst_t                    o_inst
);
    import issueIsaPkg::*;
    import issueBundlePkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_REQ,
        LINK_RELEASE
    } linkState_t;

    inst_t              mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   rdPtr;
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtrNext;
    logic [PTR_W-1:0]   wrPtrNext;
    logic [PTR_W-1:0]   wrSlot [BUNDLE_SLOTS];
    logic [COUNT_W-1:0] used;
    logic [COUNT_W-1:0] pushCount;
    logic               pop;
    linkState_t         linkState;

    // ring position of each incoming list entry
    always_comb begin
        for (int k = 0; k < BUNDLE_SLOTS; k++) begin
            wrSlot[k] = PTR_W'((int'(wrPtr) + k) % QUEUE_DEPTH);
        end
    end

    assign pushCount = i_push ? i_count : '0;
    assign wrPtrNext = PTR_W'((int'(wrPtr) + int'(pushCount)) % QUEUE_DEPTH);
    assign rdPtrNext = (int'(rdPtr) == QUEUE_DEPTH - 1) ? '0 : rdPtr + PTR_W'(1);

    // head leaves at the edge where ack is seen
    assign pop = (linkState == LINK_REQ) && i_ack;

    always_ff @(posedge w_fire00_1) begin
        if (i_push) begin
            for (int k = 0; k < BUNDLE_SLOTS; k++) begin
                if (COUNT_W'(k) < i_count) begin
                    mem[wrSlot[k]] <= i_list[k];
                end
            end
        end
    end

    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            rdPtr <= '0;
            wrPtr <= '0;
            used  <= '0;
        end else begin
            wrPtr <= wrPtrNext;
            if (pop) begin
                rdPtr <= rdPtrNext;
            end
            used <= used + pushCount - COUNT_W'(pop);
        end
    end

    // output link, one word per full handshake
    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            linkState <= LINK_IDLE;
        end else begin
            case (linkState)
                LINK_IDLE: begin
                    if (used != '0) begin
                        linkState <= LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (i_ack) begin
                        linkState <= LINK_RELEASE;
                    end
                end
                LINK_RELEASE: begin
                    // unit must drop ack before the next word
                    if (!i_ack) begin
                        linkState <= LINK_IDLE;
                    end
                end
                default: linkState <= LINK_IDLE;
            endcase
        end
    end

    assign o_req  = (linkState == LINK_REQ);
    assign o_inst = mem[rdPtr];
    assign o_free = COUNT_W'(QUEUE_DEPTH) - used;

endmodule

// ==== verilog/bundleAcceptor.sv ====
module bundleAcceptor (
    input  logic                               w_fire00_1,
    input  logic                               rstn,
    input  logic                               i_bundleReq,
    output logic                               o_bundleAck,
    input  issueBundlePkg::classCount_t        i_counts,
    input  logic [issueBundlePkg::COUNT_W-1:0] i_aluFree,
    input  logic [issueBundlePkg::COUNT_W-1:0] i_lsuFree,
    input  logic [issueBundlePkg::COUNT_W-1:0] i_csrFree,
    output logic                               o_push
);
    logic aluFits;
    logic lsuFits;
    logic csrFits;
    logic roomForAll;
    logic accept;

    assign aluFits    = i_counts.aluCount <= i_aluFree;
    assign lsuFits    = i_counts.lsuCount <= i_lsuFree;
    assign csrFits    = i_counts.csrCount <= i_csrFree;
    assign roomForAll = aluFits && lsuFits && csrFits;

    // fresh request, previous handshake closed, every queue has room
    assign accept = i_bundleReq && !o_bundleAck && roomForAll;

    // queues write at the accepting edge while upstream still holds data
    assign o_push = accept;

    // ack held until req seen low
    always_ff @(posedge w_fire00_1 or negedge rstn) begin
        if (!rstn) begin
            o_bundleAck <= 1'b0;
        end else if (accept) begin
            o_bundleAck <= 1'b1;
        end else if (o_bundleAck && !i_bundleReq) begin
            o_bundleAck <= 1'b0;
        end
    end

endmodule

// ==== verilog/opcodeClassifier.sv ====
module opcodeClassifier #(
    parameter int BUNDLE_SLOTS = 8
) (
    input  issueIsaPkg::inst_t [BUNDLE_SLOTS-1:0] i_bundle,
    input  issueBundlePkg::bundleCtl_t            i_bundleCtl,
    output issueBundlePkg::classCount_t           o_counts,
    output issueIsaPkg::inst_t [BUNDLE_SLOTS-1:0] o_aluList,
    output issueIsaPkg::inst_t [BUNDLE_SLOTS-1:0] o_lsuList,
    output issueIsaPkg::inst_t [BUNDLE_SLOTS-1:0] o_csrList
);
    import issueIsaPkg::*;
    import issueBundlePkg::*;

    localparam int LIST_IDX_W = (BUNDLE_SLOTS > 1) ? $clog2(BUNDLE_SLOTS) : 1;

    logic [BUNDLE_SLOTS-1:0] slotValid;
    issueClass_t             slotClass [BUNDLE_SLOTS];

    // branch window and opcode decode per slot
    always_comb begin
        for (int s = 0; s < BUNDLE_SLOTS; s++) begin
            slotValid[s] = !i_bundleCtl.hasBranch ||
                           (SLOT_IDX_W'(s) <= i_bundleCtl.branchIndex);
            case (i_bundle[s].opcode)
                OPC_LOAD, OPC_STORE, OPC_AMO: slotClass[s] = CLASS_LSU;
                OPC_SYSTEM:                   slotClass[s] = CLASS_CSR;
                default:                      slotClass[s] = CLASS_ALU;
            endcase
        end
    end

    // pack each class to the front of its list, slot order kept
    always_comb begin
        logic [COUNT_W-1:0] aluCnt;
        logic [COUNT_W-1:0] lsuCnt;
        logic [COUNT_W-1:0] csrCnt;

        aluCnt    = '0;
        lsuCnt    = '0;
        csrCnt    = '0;
        o_aluList = '0;
        o_lsuList = '0;
        o_csrList = '0;

        for (int s = 0; s < BUNDLE_SLOTS; s++) begin
            if (slotValid[s]) begin
                case (slotClass[s])
                    CLASS_LSU: begin
                        o_lsuList[lsuCnt[LIST_IDX_W-1:0]] = i_bundle[s];
                        lsuCnt = lsuCnt + COUNT_W'(1);
                    end
                    CLASS_CSR: begin
                        o_csrList[csrCnt[LIST_IDX_W-1:0]] = i_bundle[s];
                        csrCnt = csrCnt + COUNT_W'(1);
                    end
                    default: begin
                        o_aluList[aluCnt[LIST_IDX_W-1:0]] = i_bundle[s];
                        aluCnt = aluCnt + COUNT_W'(1);
                    end
                endcase
            end
        end

        o_counts.aluCount = aluCnt;
        o_counts.lsuCount = lsuCnt;
        o_counts.csrCount = csrCnt;
    end

endmodule

// ==== verilog/issueBundlePkg.sv ====
package issueBundlePkg;

    // up to 16 slots per bundle
    localparam int SLOT_IDX_W = 4;

    // slot counts and free space, must hold a full bundle
    localparam int COUNT_W = SLOT_IDX_W + 1;

    // branchIndex only meaningful with hasBranch set
    typedef struct packed {
        logic                  hasBranch;
        logic [SLOT_IDX_W-1:0] branchIndex;
    } bundleCtl_t;

    // per-class share of the current bundle
    typedef struct packed {
        logic [COUNT_W-1:0] aluCount;
        logic [COUNT_W-1:0] lsuCount;
        logic [COUNT_W-1:0] csrCount;
    } classCount_t;

endpackage

// ==== verilog/issueIsaPkg.sv ====
package issueIsaPkg;

    localparam int INST_W   = 32;
    localparam int OPCODE_W = 7;

    // major opcodes that leave the ALU path
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_AMO    = 7'b0101111;
    localparam logic [OPCODE_W-1:0] OPC_SYSTEM = 7'b1110011;

    // opcode sits in the low bits of the word
    typedef struct packed {
        logic [INST_W-OPCODE_W-1:0] body;
        logic [OPCODE_W-1:0]        opcode;
    } inst_t;

    // which execution queue a slot goes to
    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_LSU = 2'd1,
        CLASS_CSR = 2'd2
    } issueClass_t;

endpackage
